// File: Makefile
# Verilator build and run for the backup-RAM transfer engine

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_backup_top
FILELIST  ?= all.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)

// File: all.f
design/backup_pkg.sv
design/bram_port_if.sv
design/save_type_tracker.sv
design/backup_control.sv
design/block_buffer.sv
design/block_mover.sv
design/backup_top.sv
testbench/tb_backup_top.sv

// File: design/backup_control.sv
`default_nettype none

module backup_control (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       bk_load,        // Menu reload level
	input  wire                       bk_save,        // Menu save level
	input  wire                       bk_autosave,    // Autosave option
	input  wire                       osd_status,     // OSD open
	input  wire                       cart_download,
	input  wire                       img_mounted,
	input  wire                       bk_ena,
	input  wire                       bk_pending,
	input  wire backup_pkg::save_sz_t save_sz,
	output backup_pkg::lba_t          sd_lba,         // Current SD block
	output logic                      sd_rd,          // Held until sd_ack rises
	output logic                      sd_wr,
	input  wire                       sd_ack,         // High for the block data phase
	output logic                      xfer_start,     // Mover run level
	input  wire                       xfer_done,      // Mover finished the block
	output logic                      loading,        // Direction SD to memory
	output logic [7:0]                lba_low,        // Block part of the memory address
	output logic                      bk_busy         // Job running
);

	// Per-block steps, used by both directions
	localparam logic [1:0] ST_ISSUE  = 2'd0;  // Start SD read or mover
	localparam logic [1:0] ST_WAIT   = 2'd1;  // Wait for SD phase or mover
	localparam logic [1:0] ST_FINISH = 2'd2;  // Close the block

	logic       load_q;   // Registered trigger inputs
	logic       load_qq;
	logic       save_q;
	logic       save_qq;
	logic       auto_q;
	logic       auto_qq;
	logic       mount_q;  // Mount seen during cartridge download
	logic       ack_q;
	logic       load_edge;
	logic       save_edge;
	logic       auto_edge;
	logic       trigger;
	logic       ack_rise;
	logic       ack_fall;
	logic [1:0] step;

	assign lba_low = sd_lba[7:0];

	assign load_edge = load_q & ~load_qq;
	assign save_edge = save_q & ~save_qq;
	assign auto_edge = auto_q & ~auto_qq & bk_pending;  // Only with unsaved data
	assign trigger   = bk_ena & (load_edge | save_edge | auto_edge | mount_q);

	assign ack_rise = ~ack_q & sd_ack;
	assign ack_fall = ack_q & ~sd_ack;  // End of the block data phase

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q     <= 1'b0;
			load_qq    <= 1'b0;
			save_q     <= 1'b0;
			save_qq    <= 1'b0;
			auto_q     <= 1'b0;
			auto_qq    <= 1'b0;
			mount_q    <= 1'b0;
			ack_q      <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			xfer_start <= 1'b0;
			loading    <= 1'b0;
			bk_busy    <= 1'b0;
			step       <= ST_ISSUE;
		end else begin
			load_q  <= bk_load;
			load_qq <= load_q;
			save_q  <= bk_save;
			save_qq <= save_q;
			auto_q  <= osd_status & bk_autosave;
			auto_qq <= auto_q;
			mount_q <= img_mounted & cart_download;
			ack_q   <= sd_ack;

			// Host took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				xfer_start <= 1'b0;
				step       <= ST_ISSUE;
				sd_lba     <= '0;
				loading    <= 1'b0;
				if (trigger) begin
					bk_busy <= 1'b1;
					loading <= load_edge | mount_q;  // Mount always reloads
				end
			end else if (loading) begin
				// Load: SD read, then mover writes memory
				case (step)
					ST_ISSUE: begin
						sd_rd <= 1'b1;
						step  <= ST_WAIT;
					end
					ST_WAIT: if (ack_fall) begin
						xfer_start <= 1'b1;  // Buffer now holds the block
						step       <= ST_FINISH;
					end
					ST_FINISH: if (xfer_done) begin
						xfer_start <= 1'b0;
						step       <= ST_ISSUE;
						sd_lba     <= sd_lba + 32'd1;
						if (&sd_lba[7:0]) bk_busy <= 1'b0;  // Full 128K every time
					end
					default: step <= ST_ISSUE;
				endcase
			end else begin
				// Save: mover reads memory, then SD write
				case (step)
					ST_ISSUE: begin
						xfer_start <= 1'b1;
						step       <= ST_WAIT;
					end
					ST_WAIT: if (xfer_done) begin
						xfer_start <= 1'b0;
						sd_wr      <= 1'b1;
						step       <= ST_FINISH;
					end
					ST_FINISH: if (ack_fall) begin
						step   <= ST_ISSUE;
						sd_lba <= sd_lba + 32'd1;
						if (sd_lba[7:0] == save_sz) bk_busy <= 1'b0;  // Last used block
					end
					default: step <= ST_ISSUE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: design/backup_pkg.sv
`default_nettype none

package backup_pkg;

	// ========================================================================
	// Block geometry
	// ========================================================================

	parameter int BLOCK_ADDR_W = 8;   // 256 words per SD block
	parameter int WORD_W       = 16;  // Save words are 16 bits wide

	// Word index inside one block
	typedef logic [BLOCK_ADDR_W-1:0] block_addr_t;

	// One save word as seen by SD host and memory
	typedef logic [WORD_W-1:0] data_word_t;

	// SD block number as the host expects it
	typedef logic [31:0] lba_t;

	// Index of the last save block, so 0 means no save at all
	typedef logic [7:0] save_sz_t;

	// Image size in bytes reported on mount
	typedef logic [63:0] img_size_t;

	// Memory word address {low block number, word index}
	typedef logic [15:0] mem_addr_t;

	// ========================================================================
	// Last block per save type
	// ========================================================================

	// Sizes are OR-ed together by the tracker, so each one is a
	// low-order mask of ones
	localparam save_sz_t SZ_EEPROM   = 8'd15;   // 8K EEPROM
	localparam save_sz_t SZ_SRAM     = 8'd63;   // 32K SRAM
	localparam save_sz_t SZ_FLASH    = 8'd127;  // 64K Flash
	localparam save_sz_t SZ_FLASH_1M = 8'd255;  // 128K Flash

endpackage

`default_nettype wire

// File: design/backup_top.sv
`default_nettype none

module backup_top (
	input  wire                          clk_sys,
	input  wire                          reset,

	// Core and menu
	input  wire                          cart_download,
	input  wire                          bus_req,
	input  wire                          save_eeprom,
	input  wire                          save_sram,
	input  wire                          save_flash,
	input  wire                          flash_1m,
	input  wire                          bk_load,
	input  wire                          bk_save,
	input  wire                          bk_autosave,
	input  wire                          osd_status,

	// SD host
	input  wire                          img_mounted,
	input  wire                          img_readonly,
	input  wire backup_pkg::img_size_t   img_size,
	output backup_pkg::lba_t             sd_lba,
	output logic                         sd_rd,
	output logic                         sd_wr,
	input  wire                          sd_ack,
	input  wire backup_pkg::block_addr_t sd_buff_addr,
	input  wire backup_pkg::data_word_t  sd_buff_dout,
	input  wire                          sd_buff_wr,
	output backup_pkg::data_word_t       sd_buff_din,

	// Memory channel
	output backup_pkg::mem_addr_t        mem_addr,
	output backup_pkg::data_word_t       mem_din,
	input  wire backup_pkg::data_word_t  mem_dout,
	output logic                         mem_req,
	output logic                         mem_rnw,
	input  wire                          mem_ack,

	// Status
	output logic                         bk_busy,
	output logic                         bk_loading,
	output logic                         bk_pending,
	output logic                         bk_ena,
	output backup_pkg::save_sz_t         save_sz
);
	import backup_pkg::*;

	logic       xfer_start;  // Control to mover
	logic       xfer_done;   // Mover to control
	logic [7:0] lba_low;

	// Mover side of the block buffer
	bram_port_if #(.ADDR_W(BLOCK_ADDR_W), .DATA_W(WORD_W)) port_a_bus ();

	save_type_tracker tracker_inst (
		.clk_sys, .reset, .cart_download, .bus_req,
		.save_eeprom, .save_sram, .save_flash, .flash_1m,
		.img_mounted, .img_readonly, .img_size,
		.bk_busy, .save_sz, .bk_ena, .bk_pending
	);

	backup_control control_inst (
		.clk_sys, .reset, .bk_load, .bk_save, .bk_autosave, .osd_status,
		.cart_download, .img_mounted, .bk_ena, .bk_pending, .save_sz,
		.sd_lba, .sd_rd, .sd_wr, .sd_ack,
		.xfer_start, .xfer_done,
		.loading (bk_loading),
		.lba_low, .bk_busy
	);

	block_buffer #(.ADDR_W(BLOCK_ADDR_W), .DATA_W(WORD_W)) buffer_inst (
		.clk_sys,
		.port_a (port_a_bus),
		.sd_buff_addr, .sd_buff_dout, .sd_buff_wr, .sd_buff_din
	);

	block_mover mover_inst (
		.clk_sys, .reset, .xfer_start, .xfer_done,
		.loading  (bk_loading),
		.lba_low,
		.buf_port (port_a_bus),
		.mem_addr, .mem_din, .mem_dout, .mem_req, .mem_rnw, .mem_ack
	);

endmodule

`default_nettype wire

// File: design/block_buffer.sv
`default_nettype none

module block_buffer #(
	parameter int ADDR_W = 8,   // Words per block as a power of two
	parameter int DATA_W = 16   // Word width
) (
	input  wire                          clk_sys,
	bram_port_if.ram                     port_a,        // Mover side
	input  wire backup_pkg::block_addr_t sd_buff_addr,  // SD host side
	input  wire backup_pkg::data_word_t  sd_buff_dout,  // Data from the SD image
	input  wire                          sd_buff_wr,
	output backup_pkg::data_word_t       sd_buff_din    // Data towards the SD image
);

	// ========================================================================
	// Storage
	// ========================================================================

	logic [DATA_W-1:0] mem [2**ADDR_W];  // One SD block

	// Both ports read every cycle and write on their own strobe.
	// A same-word collision keeps the SD side, but the two sides never
	// run at once because control serializes SD phase and mover
	always_ff @(posedge clk_sys) begin
		if (port_a.wren) begin
			mem[port_a.addr] <= port_a.wdata;  // Memory word on save
		end
		if (sd_buff_wr) begin
			mem[sd_buff_addr] <= sd_buff_dout;  // SD word on load
		end

		port_a.rdata <= mem[port_a.addr];    // Towards memory
		sd_buff_din  <= mem[sd_buff_addr];   // Towards the host
	end

endmodule

`default_nettype wire

// File: design/block_mover.sv
`default_nettype none

module block_mover (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         xfer_start,  // Run level from control
	output logic                        xfer_done,   // Held until xfer_start falls
	input  wire                         loading,     // Buffer to memory when high
	input  wire [7:0]                   lba_low,     // Block part of the address
	bram_port_if.mover                  buf_port,    // Block buffer port A
	output backup_pkg::mem_addr_t       mem_addr,
	output backup_pkg::data_word_t      mem_din,
	input  wire backup_pkg::data_word_t mem_dout,
	output logic                        mem_req,     // One-clock request pulse
	output logic                        mem_rnw,     // Read when high
	input  wire                         mem_ack      // One-clock completion pulse
);
	import backup_pkg::*;

	block_addr_t word_addr;  // Current word in the block
	logic        wait_ack;   // Request outstanding

	// ========================================================================
	// Memory channel
	// ========================================================================

	// Address and direction hold for the whole request
	assign mem_addr = {lba_low, word_addr};
	assign mem_rnw  = ~loading;

	// Buffer read is registered, so the word is ready one clock after
	// word_addr moves and the request only goes out after that
	assign mem_din = buf_port.rdata;

	// ========================================================================
	// Buffer port
	// ========================================================================

	assign buf_port.addr  = word_addr;
	assign buf_port.wdata = mem_dout;                           // Read data on save
	assign buf_port.wren  = mem_ack & wait_ack & ~loading;      // Store before addr moves

	// ========================================================================
	// Word sequencer
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		mem_req <= 1'b0;  // Pulse by default

		if (reset || !xfer_start) begin
			word_addr <= '0;
			wait_ack  <= 1'b0;
			xfer_done <= 1'b0;
		end else if (!xfer_done) begin
			if (!wait_ack) begin
				mem_req  <= 1'b1;  // One request per word
				wait_ack <= 1'b1;
			end else if (mem_ack) begin
				wait_ack <= 1'b0;
				if (word_addr != '1) begin
					word_addr <= word_addr + 1'b1;
				end else begin
					xfer_done <= 1'b1;  // Last word acknowledged
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/bram_port_if.sv
`default_nettype none

// Port A of the block buffer, owned by the block mover
interface bram_port_if #(
	parameter int ADDR_W = 8,   // Word index width
	parameter int DATA_W = 16   // Word width
);

	logic [ADDR_W-1:0] addr;   // Word index, read every cycle
	logic [DATA_W-1:0] wdata;  // Data from memory on save
	logic              wren;   // Single-cycle write strobe
	logic [DATA_W-1:0] rdata;  // Registered, one clock behind addr

	// Mover side walks the block
	modport mover (
		output addr,
		output wdata,
		output wren,
		input  rdata
	);

	// RAM side answers with registered data
	modport ram (
		input  addr,
		input  wdata,
		input  wren,
		output rdata
	);

endinterface

`default_nettype wire

// File: design/save_type_tracker.sv
`default_nettype none

module save_type_tracker (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        cart_download,  // High while the ROM is written
	input  wire                        bus_req,        // Core save-area access strobe
	input  wire                        save_eeprom,    // Save type seen by the core
	input  wire                        save_sram,
	input  wire                        save_flash,
	input  wire                        flash_1m,       // Flash is the 128K part
	input  wire                        img_mounted,    // Strobe from the SD host
	input  wire                        img_readonly,
	input  wire backup_pkg::img_size_t img_size,       // Bytes
	input  wire                        bk_busy,        // Load or save job running
	output backup_pkg::save_sz_t       save_sz,        // Last save block
	output logic                       bk_ena,         // Save area exists
	output logic                       bk_pending      // Unsaved writes by the core
);
	import backup_pkg::*;

	logic     old_download;  // Edge detect on cart_download
	logic     use_img;       // Size taken from a mounted image
	logic     save_write;    // Core touched the save area
	logic     img_usable;
	save_sz_t size_mask;     // Mask of the active save types
	save_sz_t img_last_blk;  // Image bytes / 512 - 1

	// ========================================================================
	// Size decode
	// ========================================================================

	assign save_write = bus_req & (save_eeprom | save_sram | save_flash);

	// Readonly or empty images never define the save size
	assign img_usable   = img_mounted && (img_size != '0) && !img_readonly;
	assign img_last_blk = img_size[16:9] - 8'd1;  // Wraps to 255 for 128K

	always_comb begin
		size_mask = '0;
		if (save_eeprom) size_mask = size_mask | SZ_EEPROM;
		if (save_sram)   size_mask = size_mask | SZ_SRAM;
		if (save_flash) begin
			size_mask = size_mask | (flash_1m ? SZ_FLASH_1M : SZ_FLASH);  // 1M needs 256 blocks
		end
	end

	// ========================================================================
	// State
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			use_img      <= 1'b0;
			save_sz      <= '0;
			bk_pending   <= 1'b0;
		end else begin
			old_download <= cart_download;

			// New cartridge starts from scratch
			if (~old_download & cart_download) begin
				use_img <= 1'b0;
				save_sz <= '0;
			end

			// Grow with every access while the image does not own the size
			if (bus_req & ~use_img) save_sz <= save_sz | size_mask;

			// Image size wins and locks out the bus
			if (img_usable) begin
				use_img <= 1'b1;
				save_sz <= img_last_blk;
			end

			if (save_write)   bk_pending <= 1'b1;  // Dirty from the first write
			else if (bk_busy) bk_pending <= 1'b0;  // Job in flight takes the data
		end
	end

	assign bk_ena = |save_sz;

endmodule

`default_nettype wire

// File: testbench/tb_backup_top.sv
`default_nettype none

module tb_backup_top;
	import backup_pkg::*;

	localparam int LONG_WAIT = 1000000;  // Cycles for a whole load or save job

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        cart_download, bus_req, save_eeprom, save_sram, save_flash, flash_1m;
	logic        bk_load, bk_save, bk_autosave, osd_status;
	logic        img_mounted, img_readonly;
	img_size_t   img_size;
	lba_t        sd_lba;
	logic        sd_rd, sd_wr, sd_ack, sd_buff_wr;
	block_addr_t sd_buff_addr;
	data_word_t  sd_buff_dout, sd_buff_din;
	mem_addr_t   mem_addr;
	data_word_t  mem_din, mem_dout;
	logic        mem_req, mem_rnw, mem_ack;
	logic        bk_busy, bk_loading, bk_pending, bk_ena;
	save_sz_t    save_sz;

	// Models and bookkeeping
	data_word_t  file_data [256][256];  // SD image, block then word
	data_word_t  mem_model [65536];
	integer      seed = 32'h78d600da;
	int          errors = 0;
	int          timeouts = 0;
	int          sd_reads, sd_writes, mem_writes;
	lba_t        exp_lba;       // Next block the host should see
	logic        exp_loading;   // Direction of the job started by the stimulus
	logic        req_open;      // Memory request outstanding
	mem_addr_t   req_addr;
	data_word_t  req_din;
	logic        req_rnw;
	int          req_delay;

	always #4 clk_sys = ~clk_sys;  // Period 8

	backup_top backup_top_inst (.*);

	function automatic void report_error(input string msg);
		errors++;
		$display("CHECK FAILED at time %0t: %s", $time, msg);
	endfunction

	// ========================================================================
	// Memory channel model
	// ========================================================================

	initial begin
		for (int a = 0; a < 65536; a++) begin
			mem_model[a] = {a[7:0], a[15:8]} ^ 16'h5aa5;  // Byte swap so every address bit matters
		end
		for (int b = 0; b < 256; b++) begin
			for (int w = 0; w < 256; w++) begin
				file_data[b][w] = {b[7:0], w[7:0]} ^ 16'hc33c;
			end
		end
	end

	always @(posedge clk_sys) begin
		mem_ack <= 1'b0;  // Ack is a single pulse
		if (reset) begin
			req_open <= 1'b0;
		end else begin
			if (req_open) begin
				if (req_delay == 0) begin
					mem_ack  <= 1'b1;
					req_open <= 1'b0;
					if (req_rnw) begin
						mem_dout <= mem_model[req_addr];  // Valid with the ack
					end else begin
						assert (req_din == file_data[req_addr[15:8]][req_addr[7:0]])
							else report_error($sformatf("memory write %h data %h",
								req_addr, req_din));
						mem_model[req_addr] = req_din;
						mem_writes++;
					end
				end else begin
					req_delay <= req_delay - 1;
				end
			end
			if (mem_req) begin
				req_open  <= 1'b1;
				req_addr  <= mem_addr;
				req_din   <= mem_din;
				req_rnw   <= mem_rnw;
				req_delay <= $random(seed) & 3;  // 0 to 3 extra cycles
				assert (mem_rnw == !exp_loading)
					else report_error($sformatf("mem_rnw %0b with job direction load %0b",
						mem_rnw, exp_loading));
			end
		end
	end

	// One request at a time, held steady until the ack
	assert property (@(posedge clk_sys) disable iff (reset) mem_req |-> !req_open)
		else report_error("mem_req while a request is outstanding");
	assert property (@(posedge clk_sys) disable iff (reset)
		req_open |-> (mem_addr == req_addr && mem_din == req_din && mem_rnw == req_rnw))
		else report_error("memory request changed before mem_ack");

	// ========================================================================
	// SD host model
	// ========================================================================

	task automatic serve_block();
		logic rd;
		lba_t lba;
		rd  = sd_rd;
		lba = sd_lba;
		assert (lba == exp_lba) else report_error($sformatf("sd_lba %0d expected %0d",
			lba, exp_lba));
		exp_lba++;
		sd_ack <= 1'b1;
		if (rd) begin
			sd_reads++;
			for (int w = 0; w < 256; w++) begin
				@(posedge clk_sys);
				sd_buff_addr <= block_addr_t'(w);
				sd_buff_dout <= file_data[lba[7:0]][w];
				sd_buff_wr   <= 1'b1;
			end
			@(posedge clk_sys);
			sd_buff_wr <= 1'b0;
		end else begin
			sd_writes++;
			// Read data trails the address by two loop steps
			for (int i = 0; i < 258; i++) begin
				@(posedge clk_sys);
				if (i >= 2) begin
					assert (sd_buff_din == mem_model[{lba[7:0], 8'(i - 2)}])
						else report_error($sformatf("block %0d word %0d saved as %h",
							lba, i - 2, sd_buff_din));
					file_data[lba[7:0]][i - 2] = sd_buff_din;
				end
				if (i < 256) sd_buff_addr <= block_addr_t'(i);
			end
		end
		sd_ack <= 1'b0;  // Ends the data phase
	endtask

	always begin
		@(posedge clk_sys);
		if (!reset && (sd_rd || sd_wr) && !sd_ack) serve_block();
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	task automatic wait_busy(input logic level, input int limit, output bit ok);
		int n;
		n = 0;
		while (bk_busy !== level && n < limit) begin
			@(posedge clk_sys);
			n++;
		end
		ok = (bk_busy === level);
		if (!ok) begin
			timeouts++;
			$display("Timeout at %0t: bk_busy did not go %0b within %0d cycles",
				$time, level, limit);
		end
	endtask

	task automatic run_job(input bit load, output bit ok);
		wait_busy(1'b1, 20, ok);
		if (!ok) return;
		assert (bk_loading == load) else report_error("wrong job direction");
		wait_busy(1'b0, LONG_WAIT, ok);
	endtask

	task automatic run_tests();
		bit ok;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		@(posedge clk_sys);
		assert (!sd_rd && !sd_wr && !mem_req && !bk_busy && !bk_pending && !bk_ena)
			else report_error("outputs not idle after reset");

		// Download, then one EEPROM access
		cart_download <= 1'b1;
		repeat (2) @(posedge clk_sys);
		cart_download <= 1'b0;
		bus_req       <= 1'b1;
		save_eeprom   <= 1'b1;
		@(posedge clk_sys);
		bus_req <= 1'b0;
		repeat (2) @(posedge clk_sys);
		assert (bk_ena && bk_pending && save_sz == 8'd15)
			else report_error($sformatf("after EEPROM access save_sz %0d", save_sz));

		// Autosave with a pending write
		exp_lba     = '0;
		sd_writes   = 0;
		bk_autosave <= 1'b1;
		osd_status  <= 1'b1;
		wait_busy(1'b1, 20, ok);
		if (!ok) return;
		repeat (2) @(posedge clk_sys);
		assert (!bk_pending) else report_error("bk_pending kept during job");
		wait_busy(1'b0, LONG_WAIT, ok);
		if (!ok) return;
		osd_status <= 1'b0;
		assert (sd_writes == 16) else report_error($sformatf("autosave wrote %0d", sd_writes));

		// Autosave with nothing pending
		repeat (4) @(posedge clk_sys);
		osd_status <= 1'b1;
		repeat (20) begin
			@(posedge clk_sys);
			assert (!bk_busy) else report_error("autosave ran without pending data");
		end
		osd_status <= 1'b0;

		// Menu save
		exp_lba   = '0;
		sd_writes = 0;
		bk_save <= 1'b1;
		run_job(1'b0, ok);
		if (!ok) return;
		bk_save <= 1'b0;
		assert (sd_writes == 16 && exp_lba == 16)
			else report_error($sformatf("menu save wrote %0d blocks", sd_writes));

		// Image mounted during download loads every block
		exp_lba     = '0;
		sd_reads    = 0;
		mem_writes  = 0;
		exp_loading = 1'b1;
		cart_download <= 1'b1;
		repeat (2) @(posedge clk_sys);
		img_size    <= 64'd8192;
		img_mounted <= 1'b1;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		run_job(1'b1, ok);
		if (!ok) return;
		exp_loading = 1'b0;
		cart_download <= 1'b0;
		assert (sd_reads == 256 && mem_writes == 65536 && save_sz == 8'd15)
			else report_error($sformatf("load read %0d blocks, %0d words",
				sd_reads, mem_writes));

		// Save after the load stops at block 15
		exp_lba   = '0;
		sd_writes = 0;
		@(posedge clk_sys);
		bk_save <= 1'b1;
		run_job(1'b0, ok);
		if (!ok) return;
		bk_save <= 1'b0;
		assert (sd_writes == 16) else report_error($sformatf("save wrote %0d", sd_writes));
	endtask

	initial begin
		exp_loading   = 1'b0;
		reset         <= 1'b1;
		cart_download <= 1'b0;
		bus_req       <= 1'b0;
		save_eeprom   <= 1'b0;
		save_sram     <= 1'b0;
		save_flash    <= 1'b0;
		flash_1m      <= 1'b0;
		bk_load       <= 1'b0;
		bk_save       <= 1'b0;
		bk_autosave   <= 1'b0;
		osd_status    <= 1'b0;
		img_mounted   <= 1'b0;
		img_readonly  <= 1'b0;
		img_size      <= '0;
		sd_ack        <= 1'b0;
		sd_buff_addr  <= '0;
		sd_buff_dout  <= '0;
		sd_buff_wr    <= 1'b0;
		mem_dout      <= '0;
		mem_ack       <= 1'b0;
		run_tests();
		repeat (4) @(posedge clk_sys);
		$display("Done: %0d checks failed, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
